//--- Makefile
SRCS := $(wildcard hdl/*.sv) $(wildcard verification/*.sv)
BIN  := obj_dir/Vtb_audio_player

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) audio_player.f
	verilator --binary --timing --assert -j 0 --top-module tb_audio_player -f audio_player.f

sim.log: $(BIN)
	./$(BIN) > sim.log; cat sim.log

run: sim.log

check: sim.log
	@grep -q "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- audio_player.f
hdl/player_pkg.sv
hdl/button_sync.sv
hdl/button_repeat.sv
hdl/rate_control.sv
hdl/kbd_command.sv
hdl/flash_reader.sv
hdl/audio_player_top.sv
verification/tb_flash_model.sv
verification/tb_audio_player.sv

//--- hdl/audio_player_top.sv
`timescale 1ns/1ps

module audio_player_top #(
  parameter int DEFAULT_DIV   = 1135,
  parameter int SPEED_STEP    = 16,
  parameter int MIN_DIV       = 255,
  parameter int MAX_DIV       = 4095,
  parameter int REPEAT_CYCLES = 5000000,
  parameter int ADDR_MAX      = 'h7FFFF
) (
  input  logic                    CLK_50M,
  input  logic                    rst_n,
  input  logic [2:0]              KEY,
  input  player_pkg::scan_code_t  scan_code,
  input  logic                    scan_valid,
  output logic                    flash_read,
  output player_pkg::flash_addr_t flash_address,
  input  logic                    flash_waitrequest,
  input  player_pkg::flash_word_t flash_readdata,
  input  logic                    flash_readdatavalid,
  output player_pkg::sample_t     audio_sample,
  output player_pkg::div_count_t  rate_count
);

  logic [player_pkg::NUM_BUTTONS-1:0] held;
  logic [player_pkg::NUM_BUTTONS-1:0] rep_event;
  logic                               norm_held;
  logic                               sample_tick;
  logic                               play;
  player_pkg::dir_e                   direction;
  logic                               restart;

  // ==============================
  // Rate buttons
  // ==============================
  button_sync u_button_sync (
    .CLK_50M   (CLK_50M),
    .rst_n     (rst_n),
    .KEY       (KEY),
    .held      (held),
    .norm_held (norm_held)
  );

  // Channel 0 speeds up, channel 1 slows down
  for (genvar g = 0; g < player_pkg::NUM_BUTTONS; g++)
  begin : g_repeat
    button_repeat #(
      .REPEAT_CYCLES (REPEAT_CYCLES)
    ) u_button_repeat (
      .CLK_50M     (CLK_50M),
      .rst_n       (rst_n),
      .held        (held[g]),
      .event_pulse (rep_event[g])
    );
  end

  rate_control #(
    .DEFAULT_DIV (DEFAULT_DIV),
    .SPEED_STEP  (SPEED_STEP),
    .MIN_DIV     (MIN_DIV),
    .MAX_DIV     (MAX_DIV)
  ) u_rate_control (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .up_event    (rep_event[0]),
    .down_event  (rep_event[1]),
    .norm_held   (norm_held),
    .div_count   (rate_count),
    .sample_tick (sample_tick)
  );

  // ==============================
  // Keyboard and flash playback
  // ==============================
  kbd_command u_kbd_command (
    .CLK_50M    (CLK_50M),
    .rst_n      (rst_n),
    .scan_code  (scan_code),
    .scan_valid (scan_valid),
    .play       (play),
    .direction  (direction),
    .restart    (restart)
  );

  flash_reader #(
    .ADDR_MAX (ADDR_MAX)
  ) u_flash_reader (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .sample_tick         (sample_tick),
    .play                (play),
    .direction           (direction),
    .restart             (restart),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .audio_sample        (audio_sample)
  );

endmodule

//--- hdl/button_repeat.sv
`timescale 1ns/1ps

module button_repeat #(
  parameter int REPEAT_CYCLES = 5000000
) (
  input  logic CLK_50M,
  input  logic rst_n,
  input  logic held,
  output logic event_pulse
);

  localparam int CNT_W = (REPEAT_CYCLES > 1) ? $clog2(REPEAT_CYCLES) : 1;
  localparam logic [CNT_W-1:0] LAST_COUNT = CNT_W'(REPEAT_CYCLES - 1);

  logic [CNT_W-1:0] prescale;
  logic             wrap;

  assign wrap = (prescale == LAST_COUNT);

  // ==============================
  // Free-running prescaler
  // ==============================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      prescale <= '0;
    end
    else if (wrap)
    begin
      prescale <= '0;
    end
    else
    begin
      prescale <= prescale + 1'b1;
    end
  end

  // One event per wrap while the button is down
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      event_pulse <= 1'b0;
    end
    else
    begin
      event_pulse <= wrap && held;
    end
  end

endmodule

//--- hdl/button_sync.sv
`timescale 1ns/1ps

module button_sync (
  input  logic                                CLK_50M,
  input  logic                                rst_n,
  input  logic [2:0]                          KEY,
  output logic [player_pkg::NUM_BUTTONS-1:0]  held,
  output logic                                norm_held
);

  logic [2:0] key_meta;
  logic [2:0] key_sync;

  // Keys are active low, so invert on the way in
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      key_meta <= '0;
      key_sync <= '0;
    end
    else
    begin
      key_meta <= ~KEY;
      key_sync <= key_meta;
    end
  end

  // KEY[0] up, KEY[1] down
  assign held = key_sync[player_pkg::NUM_BUTTONS-1:0];

  // KEY[2] restores the default rate
  assign norm_held = key_sync[2];

endmodule

//--- hdl/flash_reader.sv
`timescale 1ns/1ps

module flash_reader #(
  parameter int ADDR_MAX = 'h7FFFF
) (
  input  logic                    CLK_50M,
  input  logic                    rst_n,
  input  logic                    sample_tick,
  input  logic                    play,
  input  player_pkg::dir_e        direction,
  input  logic                    restart,
  output logic                    flash_read,
  output player_pkg::flash_addr_t flash_address,
  input  logic                    flash_waitrequest,
  input  player_pkg::flash_word_t flash_readdata,
  input  logic                    flash_readdatavalid,
  output player_pkg::sample_t     audio_sample
);

  localparam player_pkg::flash_addr_t LAST_ADDR = player_pkg::flash_addr_t'(ADDR_MAX);

  player_pkg::reader_state_e state;
  player_pkg::sample_t       spare_half;
  logic                      half_left;
  logic                      restart_pend;
  player_pkg::flash_addr_t   next_addr;
  player_pkg::flash_addr_t   restart_addr;

  // Step with wrap between 0 and the last word
  always_comb
  begin
    if (direction == player_pkg::dir_fwd)
    begin
      next_addr    = (flash_address == LAST_ADDR) ? '0 : flash_address + 1'b1;
      restart_addr = '0;
    end
    else
    begin
      next_addr    = (flash_address == '0) ? LAST_ADDR : flash_address - 1'b1;
      restart_addr = LAST_ADDR;
    end
  end

  assign flash_read = (state == player_pkg::st_request);

  // ==============================
  // Fetch FSM
  // ==============================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state         <= player_pkg::st_idle;
      flash_address <= '0;
      half_left     <= 1'b0;
      restart_pend  <= 1'b0;
      audio_sample  <= '0;
    end
    else
    begin
      case (state)
        player_pkg::st_idle:
        begin
          if (restart || restart_pend)
          begin
            flash_address <= restart_addr;
            half_left     <= 1'b0;
            restart_pend  <= 1'b0;
          end
          else if (sample_tick && play)
          begin
            if (half_left)
            begin
              audio_sample <= spare_half;
              half_left    <= 1'b0;
            end
            else
            begin
              state <= player_pkg::st_request;
            end
          end
        end

        player_pkg::st_request:
        begin
          // Address must hold still until the flash takes it
          if (restart)
          begin
            restart_pend <= 1'b1;
          end
          if (!flash_waitrequest)
          begin
            state <= player_pkg::st_wait_data;
          end
        end

        player_pkg::st_wait_data:
        begin
          if (restart)
          begin
            restart_pend <= 1'b1;
          end
          if (flash_readdatavalid)
          begin
            state <= player_pkg::st_idle;
            if (!restart && !restart_pend)
            begin
              // First half of the new word goes out now
              if (direction == player_pkg::dir_fwd)
              begin
                audio_sample <= flash_readdata[15:0];
              end
              else
              begin
                audio_sample <= flash_readdata[31:16];
              end
              half_left     <= 1'b1;
              flash_address <= next_addr;
            end
          end
        end

        default:
        begin
          state <= player_pkg::st_idle;
        end
      endcase
    end
  end

  // Second half in the order chosen at fetch time
  always_ff @(posedge CLK_50M)
  begin
    if (state == player_pkg::st_wait_data && flash_readdatavalid)
    begin
      if (direction == player_pkg::dir_fwd)
      begin
        spare_half <= flash_readdata[31:16];
      end
      else
      begin
        spare_half <= flash_readdata[15:0];
      end
    end
  end

endmodule

//--- hdl/kbd_command.sv
`timescale 1ns/1ps

module kbd_command (
  input  logic                   CLK_50M,
  input  logic                   rst_n,
  input  player_pkg::scan_code_t scan_code,
  input  logic                   scan_valid,
  output logic                   play,
  output player_pkg::dir_e       direction,
  output logic                   restart
);

  player_pkg::kbd_cmd_e cmd;
  logic                 skip_next;

  // Byte to opcode
  always_comb
  begin
    case (scan_code)
      player_pkg::SCAN_E: cmd = player_pkg::cmd_play;
      player_pkg::SCAN_D: cmd = player_pkg::cmd_pause;
      player_pkg::SCAN_F: cmd = player_pkg::cmd_fwd;
      player_pkg::SCAN_B: cmd = player_pkg::cmd_bwd;
      player_pkg::SCAN_R: cmd = player_pkg::cmd_restart;
      default:            cmd = player_pkg::cmd_none;
    endcase
  end

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      play      <= 1'b0;
      direction <= player_pkg::dir_fwd;
      restart   <= 1'b0;
      skip_next <= 1'b0;
    end
    else
    begin
      restart <= 1'b0;
      if (scan_valid)
      begin
        if (skip_next)
        begin
          // Code after F0 belongs to a key release
          skip_next <= 1'b0;
        end
        else if (scan_code == player_pkg::SCAN_BREAK)
        begin
          skip_next <= 1'b1;
        end
        else
        begin
          case (cmd)
            player_pkg::cmd_play:    play      <= 1'b1;
            player_pkg::cmd_pause:   play      <= 1'b0;
            player_pkg::cmd_fwd:     direction <= player_pkg::dir_fwd;
            player_pkg::cmd_bwd:     direction <= player_pkg::dir_bwd;
            player_pkg::cmd_restart: restart   <= 1'b1;
            default: ;
          endcase
        end
      end
    end
  end

endmodule

//--- hdl/player_pkg.sv
package player_pkg;

  // ==============================
  // Data widths
  // ==============================
  typedef logic [15:0] sample_t;
  typedef logic [31:0] flash_word_t;
  typedef logic [22:0] flash_addr_t;
  typedef logic [15:0] div_count_t;
  typedef logic [7:0]  scan_code_t;

  // ==============================
  // Enums
  // ==============================
  typedef enum logic {
    dir_fwd,
    dir_bwd
  } dir_e;

  typedef enum logic [2:0] {
    cmd_none,
    cmd_play,
    cmd_pause,
    cmd_fwd,
    cmd_bwd,
    cmd_restart
  } kbd_cmd_e;

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_wait_data
  } reader_state_e;

  // Keyboard set-2 make codes
  localparam scan_code_t SCAN_E     = 8'h24;
  localparam scan_code_t SCAN_D     = 8'h23;
  localparam scan_code_t SCAN_F     = 8'h2B;
  localparam scan_code_t SCAN_B     = 8'h32;
  localparam scan_code_t SCAN_R     = 8'h2D;
  localparam scan_code_t SCAN_BREAK = 8'hF0;

  // Up and down buttons with auto-repeat
  localparam int NUM_BUTTONS = 2;

endpackage

//--- hdl/rate_control.sv
`timescale 1ns/1ps

module rate_control #(
  parameter int DEFAULT_DIV = 1135,
  parameter int SPEED_STEP  = 16,
  parameter int MIN_DIV     = 255,
  parameter int MAX_DIV     = 4095
) (
  input  logic                   CLK_50M,
  input  logic                   rst_n,
  input  logic                   up_event,
  input  logic                   down_event,
  input  logic                   norm_held,
  output player_pkg::div_count_t div_count,
  output logic                   sample_tick
);

  player_pkg::div_count_t tick_cnt;
  int                     faster;
  int                     slower;

  // Shorter period means faster playback
  always_comb
  begin
    faster = int'(div_count) - SPEED_STEP;
    slower = int'(div_count) + SPEED_STEP;
    if (faster < MIN_DIV)
    begin
      faster = MIN_DIV;
    end
    if (slower > MAX_DIV)
    begin
      slower = MAX_DIV;
    end
  end

  // ==============================
  // Divider count register
  // ==============================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_count <= player_pkg::div_count_t'(DEFAULT_DIV);
    end
    else if (norm_held)
    begin
      div_count <= player_pkg::div_count_t'(DEFAULT_DIV);
    end
    else if (up_event && !down_event)
    begin
      div_count <= player_pkg::div_count_t'(faster);
    end
    else if (down_event && !up_event)
    begin
      div_count <= player_pkg::div_count_t'(slower);
    end
  end

  // ==============================
  // Sample tick, one every div_count+1 cycles
  // ==============================
  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tick_cnt    <= '0;
      sample_tick <= 1'b0;
    end
    else if (tick_cnt >= div_count)
    begin
      // >= so a count that just shrank cannot be overshot
      tick_cnt    <= '0;
      sample_tick <= 1'b1;
    end
    else
    begin
      tick_cnt    <= tick_cnt + 1'b1;
      sample_tick <= 1'b0;
    end
  end

endmodule

//--- verification/tb_audio_player.sv
`timescale 1ns/1ps

module tb_audio_player;

  localparam logic [31:0] PATTERN = 32'hA5C3_5A3C;
  localparam int ADDR_MAX = 7;
  // Sum of rough test lengths in cycles with a margin of two
  localparam int TEST_CYCLES = 220 + 1000 + 800 + 700 + 1100;
  localparam int LIMIT = 2 * TEST_CYCLES;

  logic                    CLK_50M = 1'b0;
  logic                    rst_n;
  logic [2:0]              KEY;
  player_pkg::scan_code_t  scan_code;
  logic                    scan_valid;
  logic                    flash_read;
  player_pkg::flash_addr_t flash_address;
  logic                    flash_waitrequest;
  player_pkg::flash_word_t flash_readdata;
  logic                    flash_readdatavalid;
  player_pkg::sample_t     audio_sample;
  player_pkg::div_count_t  rate_count;

  int                  errors = 0;
  int                  test_errors;
  int                  tests_run = 0;
  int                  tests_failed = 0;
  string               cur_test = "reset";
  int                  cycle = 0;
  player_pkg::sample_t exp_q[$];
  player_pkg::sample_t prev_sample = '0;
  player_pkg::dir_e    tb_dir = player_pkg::dir_fwd;
  int                  exp_addr = 0;
  int                  prev_acc = -1;
  int                  first_acc = -1;
  int                  pops = 0;
  int                  starts = 0;
  int                  last_start = -1;
  logic                prev_read = 1'b0;
  logic                spacing_on = 1'b0;
  logic                wrap_fwd = 1'b0;
  logic                wrap_bwd = 1'b0;

  audio_player_top #(
    .DEFAULT_DIV   (20),
    .SPEED_STEP    (4),
    .MIN_DIV       (8),
    .MAX_DIV       (40),
    .REPEAT_CYCLES (50),
    .ADDR_MAX      (ADDR_MAX)
  ) DUT (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .KEY                 (KEY),
    .scan_code           (scan_code),
    .scan_valid          (scan_valid),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .audio_sample        (audio_sample),
    .rate_count          (rate_count)
  );

  tb_flash_model #(
    .PATTERN (PATTERN)
  ) u_flash (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid)
  );

  always #10 CLK_50M = ~CLK_50M;

  // ==============================
  // Timeout
  // ==============================
  always @(posedge CLK_50M)
  begin
    cycle = cycle + 1;
    if (cycle >= LIMIT)
    begin
      $display("Timeout: run exceeded %0d cycles in test %s", LIMIT, cur_test);
      $display("TEST FAIL");
      $finish;
    end
  end

  // Address must hold while the flash stalls
  assert property (@(posedge CLK_50M) disable iff (!rst_n)
    flash_read && flash_waitrequest |=> flash_read && $stable(flash_address))
  else
  begin
    errors++;
    $display("Read request dropped or address moved during waitrequest in %s", cur_test);
  end

  assert property (@(posedge CLK_50M) disable iff (!rst_n)
    rate_count >= 8 && rate_count <= 40)
  else
  begin
    errors++;
    $display("Error %s: rate_count expected 8..40, actual %0d", cur_test, rate_count);
  end

  function automatic player_pkg::sample_t word_half(input int addr, input logic high);
    logic [31:0] word;
    word = {16'(addr * 2 + 1), 16'(addr * 2)} ^ PATTERN;
    return high ? word[31:16] : word[15:0];
  endfunction

  task automatic check_value(input string what, input int expected, input int actual);
    assert (expected == actual)
    else
    begin
      errors++;
      $display("Error %s: %s expected %0h, actual %0h", cur_test, what, expected, actual);
    end
  endtask

  // ==============================
  // Scoreboard monitors at negedge
  // ==============================
  always @(negedge CLK_50M)
  begin
    if (rst_n && flash_read && !prev_read)
    begin
      if (spacing_on && last_start >= 0)
      begin
        check_value("read spacing", 2 * (rate_count + 1), cycle - last_start);
      end
      last_start = cycle;
      starts++;
    end
    prev_read = flash_read;
    if (rst_n && flash_read && !flash_waitrequest)
    begin
      check_value("fetch address", exp_addr, flash_address);
      if (prev_acc == ADDR_MAX && flash_address == 0)
        wrap_fwd = 1'b1;
      if (prev_acc == 0 && flash_address == ADDR_MAX)
        wrap_bwd = 1'b1;
      if (first_acc < 0)
        first_acc = flash_address;
      prev_acc = flash_address;
      exp_q.push_back(word_half(exp_addr, tb_dir == player_pkg::dir_bwd));
      exp_q.push_back(word_half(exp_addr, tb_dir == player_pkg::dir_fwd));
      if (tb_dir == player_pkg::dir_fwd)
        exp_addr = (exp_addr == ADDR_MAX) ? 0 : exp_addr + 1;
      else
        exp_addr = (exp_addr == 0) ? ADDR_MAX : exp_addr - 1;
    end
    if (rst_n && audio_sample != prev_sample)
    begin
      if (exp_q.size() == 0)
      begin
        errors++;
        $display("audio_sample changed to %0h with no sample expected in %s",
                 audio_sample, cur_test);
      end
      else
      begin
        check_value("audio_sample", exp_q.pop_front(), audio_sample);
      end
      pops++;
    end
    prev_sample = audio_sample;
  end

  // ==============================
  // Stimulus tasks
  // ==============================
  task automatic send_command(input player_pkg::kbd_cmd_e cmd);
    player_pkg::scan_code_t code;
    case (cmd)
      player_pkg::cmd_play:  code = player_pkg::SCAN_E;
      player_pkg::cmd_pause: code = player_pkg::SCAN_D;
      player_pkg::cmd_fwd:   code = player_pkg::SCAN_F;
      player_pkg::cmd_bwd:   code = player_pkg::SCAN_B;
      default:               code = player_pkg::SCAN_R;
    endcase
    send_byte(code);
    if (cmd == player_pkg::cmd_fwd)
      tb_dir = player_pkg::dir_fwd;
    if (cmd == player_pkg::cmd_bwd)
      tb_dir = player_pkg::dir_bwd;
    if (cmd == player_pkg::cmd_restart)
    begin
      // The held word is thrown away
      exp_q.delete();
      exp_addr = (tb_dir == player_pkg::dir_fwd) ? 0 : ADDR_MAX;
    end
  endtask

  task automatic send_byte(input player_pkg::scan_code_t code);
    @(posedge CLK_50M);
    #2;
    scan_code  = code;
    scan_valid = 1'b1;
    @(posedge CLK_50M);
    #2;
    scan_valid = 1'b0;
    repeat (2) @(posedge CLK_50M);
  endtask

  task automatic wait_idle();
    repeat (3) @(negedge CLK_50M);
    while (flash_read)
      @(negedge CLK_50M);
    repeat (10) @(negedge CLK_50M);
  endtask

  task automatic wait_samples(input int n);
    int target;
    target = pops + n;
    while (pops < target)
      @(negedge CLK_50M);
  endtask

  task automatic watch_quiet(input int n, input string why);
    player_pkg::sample_t held_val;
    logic                bad;
    held_val = audio_sample;
    bad = 1'b0;
    repeat (n)
    begin
      @(negedge CLK_50M);
      if (flash_read || audio_sample != held_val)
        bad = 1'b1;
    end
    assert (!bad)
    else
    begin
      errors++;
      $display("Playback went on %s in %s", why, cur_test);
    end
  endtask

  task automatic hold_key(input int idx, input int n);
    @(posedge CLK_50M);
    #2;
    KEY[idx] = 1'b0;
    repeat (n) @(posedge CLK_50M);
    #2;
    KEY[idx] = 1'b1;
    repeat (6) @(negedge CLK_50M);
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_errors = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors != test_errors)
    begin
      tests_failed++;
      $display("Test %s: failed", cur_test);
    end
    else
    begin
      $display("Test %s: passed", cur_test);
    end
  endtask

  // ==============================
  // Test sequence
  // ==============================
  initial
  begin
    int steps;
    int n;
    rst_n      = 1'b0;
    KEY        = 3'b111;
    scan_code  = '0;
    scan_valid = 1'b0;
    repeat (8) @(posedge CLK_50M);
    #2;
    rst_n = 1'b1;

    start_test("reset");
    @(negedge CLK_50M);
    check_value("flash_read", 0, flash_read);
    check_value("audio_sample", 0, audio_sample);
    check_value("rate_count", 20, rate_count);
    repeat (200) @(negedge CLK_50M);
    check_value("read starts", 0, starts);
    end_test();

    start_test("forward");
    spacing_on = 1'b1;
    last_start = -1;
    send_command(player_pkg::cmd_play);
    wait_samples(40);
    check_value("wrap 7 to 0 seen", 1, wrap_fwd);
    spacing_on = 1'b0;
    end_test();

    start_test("backward");
    send_command(player_pkg::cmd_pause);
    wait_idle();
    send_command(player_pkg::cmd_bwd);
    send_command(player_pkg::cmd_restart);
    first_acc = -1;
    last_start = -1;
    spacing_on = 1'b1;
    send_command(player_pkg::cmd_play);
    wait_samples(20);
    check_value("first address", ADDR_MAX, first_acc);
    check_value("wrap 0 to 7 seen", 1, wrap_bwd);
    spacing_on = 1'b0;
    end_test();

    start_test("pause");
    send_command(player_pkg::cmd_pause);
    wait_idle();
    watch_quiet(100, "after pause");
    send_byte(player_pkg::SCAN_BREAK);
    send_byte(player_pkg::SCAN_E);
    watch_quiet(100, "after a break code");
    n = starts;
    send_command(player_pkg::cmd_play);
    while (starts == n)
      @(negedge CLK_50M);
    wait_samples(4);
    send_command(player_pkg::cmd_pause);
    wait_idle();
    end_test();

    start_test("buttons");
    hold_key(0, 100);
    steps = (20 - rate_count) / 4;
    check_value("step size remainder", 0, (20 - rate_count) % 4);
    assert (steps >= 2 && steps <= 3)
    else
    begin
      errors++;
      $display("Error %s: expected 2 to 3 steps, actual %0d", cur_test, steps);
    end
    hold_key(0, 200);
    check_value("rate_count at floor", 8, rate_count);
    hold_key(1, 500);
    check_value("rate_count at ceiling", 40, rate_count);
    @(posedge CLK_50M);
    #2;
    KEY[2] = 1'b0;
    n = 0;
    while (n < 4 && rate_count != 20)
    begin
      @(negedge CLK_50M);
      n++;
    end
    check_value("rate_count after default key", 20, rate_count);
    @(posedge CLK_50M);
    #2;
    KEY[2] = 1'b1;
    end_test();

    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule

//--- verification/tb_flash_model.sv
`timescale 1ns/1ps

module tb_flash_model #(
  parameter logic [31:0] PATTERN = 32'hA5C3_5A3C
) (
  input  logic                    CLK_50M,
  input  logic                    rst_n,
  input  logic                    flash_read,
  input  player_pkg::flash_addr_t flash_address,
  output logic                    flash_waitrequest,
  output player_pkg::flash_word_t flash_readdata,
  output logic                    flash_readdatavalid
);

  logic [31:0]             lcg_state = 32'd54;
  int                      wait_target;
  int                      wait_cnt;
  int                      lat_left;
  player_pkg::flash_addr_t addr_q;

  // Linear congruential generator from seed 54
  function automatic int next_rand(input int range);
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'(lcg_state[23:16]) % range;
  endfunction

  assign flash_waitrequest = flash_read && (wait_cnt < wait_target);

  always @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wait_cnt            <= 0;
      wait_target         <= 1;
      lat_left            <= 0;
      addr_q              <= '0;
      flash_readdata      <= '0;
      flash_readdatavalid <= 1'b0;
    end
    else
    begin
      flash_readdatavalid <= 1'b0;
      if (lat_left > 0)
      begin
        lat_left <= lat_left - 1;
        if (lat_left == 1)
        begin
          flash_readdatavalid <= 1'b1;
          flash_readdata <= {16'(addr_q * 2 + 1), 16'(addr_q * 2)} ^ PATTERN;
        end
      end
      // Accepted read returns data after 2 to 4 cycles
      if (flash_read && !flash_waitrequest)
      begin
        addr_q      <= flash_address;
        lat_left    <= 2 + next_rand(3);
        wait_cnt    <= 0;
        wait_target <= next_rand(4);
      end
      else if (flash_read)
      begin
        wait_cnt <= wait_cnt + 1;
      end
    end
  end

endmodule
